//--- hdl/cp15_settings.svh
`ifndef CP15_SETTINGS_SVH
`define CP15_SETTINGS_SVH

// ************************************************************
// CRn register numbers
// ************************************************************

`define CP15_CRN_CPUID     4'd0
`define CP15_CRN_SYSCFG    4'd1
`define CP15_CRN_TTBR      4'd2
`define CP15_CRN_DOMAIN    4'd3
`define CP15_CRN_FSR       4'd5
`define CP15_CRN_FAR       4'd6
`define CP15_CRN_CACHE     4'd7
`define CP15_CRN_TLB       4'd8
`define CP15_CRN_CACHE_LCK 4'd9
`define CP15_CRN_TLB_LCK   4'd10

// ************************************************************
// Fixed values and writable masks
// ************************************************************

`define CP15_CPUID_VALUE   32'h6605_2150
`define CP15_SYSCFG_MASK   32'h0000_3007 // M, A, C, I and V
`define CP15_SYSCFG_M_BIT  0
`define CP15_SYSCFG_V_BIT  13
`define CP15_LCK_MASK      32'hfc00_0001 // Victim base plus the preserve bit
`define CP15_CP_NUM        4'd15

`endif

//--- hdl/cp15_pkg.sv
package cp15_pkg;

	// ************************************************************
	// Data and field types
	// ************************************************************

	typedef logic [31:0] word;

	typedef logic [3:0] reg_num; // CRn, CRm or a core register

	typedef logic [2:0] cp_opcode; // op1 or op2

	typedef logic [31:14] mmu_base; // Upper bits of the TTBR

	// ************************************************************
	// Transfer direction and fault report
	// ************************************************************

	// Encoded as the L bit of the instruction
	typedef enum logic {
		CP_MCR = 1'b0,
		CP_MRC = 1'b1
	} cp_dir;

	typedef struct packed {
		logic [3:0] domain;
		logic [3:0] status;
	} fault_status;

endpackage

//--- hdl/cp15_decode.sv
`include "cp15_settings.svh"

module cp15_decode
	import cp15_pkg::*;
(
	input  logic     insn_valid,
	input  word      insn,

	output logic     transfer,
	output cp_dir    dir,
	output reg_num   crn,
	                 crm,
	output cp_opcode op1,
	                 op2,
	output reg_num   rt,
	output logic     undef
);

	logic legal, implemented, bad_dir;

	assign op1 = insn[23:21];
	assign crn = insn[19:16];
	assign rt  = insn[15:12];
	assign op2 = insn[7:5];
	assign crm = insn[3:0];

	assign dir = insn[20] ? CP_MRC : CP_MCR;

	// Register transfer class, bit 4 set, coprocessor 15
	assign legal = insn[27:24] == 4'b1110 && insn[4] && insn[11:8] == `CP15_CP_NUM;

	always_comb begin
		implemented = 1'b1;
		bad_dir = 1'b0;

		unique case (crn)
			`CP15_CRN_CPUID:
				bad_dir = dir == CP_MCR; // ID register is read only

			`CP15_CRN_SYSCFG, `CP15_CRN_TTBR, `CP15_CRN_DOMAIN,
			`CP15_CRN_FSR, `CP15_CRN_FAR,
			`CP15_CRN_CACHE_LCK, `CP15_CRN_TLB_LCK:
				bad_dir = 1'b0;

			`CP15_CRN_CACHE, `CP15_CRN_TLB:
				bad_dir = dir == CP_MRC; // Maintenance ops are write only

			default:
				implemented = 1'b0;
		endcase
	end

	assign undef = insn_valid && (!legal || !implemented || bad_dir);
	assign transfer = insn_valid && !undef;

endmodule

//--- hdl/cp15_syscfg.sv
`include "cp15_settings.svh"

module cp15_syscfg
	import cp15_pkg::*;
(
	input  logic clk,
	             rst_n,
	             transfer,
	input  word  write,

	output word  read,
	output logic mmu_enable,
	             high_vectors
);

	word ctrl;

	// ************************************************************
	// Control register
	// ************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (transfer) begin
			ctrl <= write & `CP15_SYSCFG_MASK; // Reserved bits stay zero
		end
	end

	assign read = ctrl;

	assign mmu_enable   = ctrl[`CP15_SYSCFG_M_BIT];
	assign high_vectors = ctrl[`CP15_SYSCFG_V_BIT]; // Vectors at 0xffff0000

endmodule

//--- hdl/cp15_mmu_regs.sv
`include "cp15_settings.svh"

module cp15_mmu_regs
	import cp15_pkg::*;
(
	input  logic                  clk,
	                              rst_n,
	                              transfer,
	input  reg_num                crn,
	input  word                   write,
	input  logic                  fault,
	input  word                   fault_addr,
	input  cp15_pkg::fault_status fault_status,

	output word                   read,
	output mmu_base               mmu_ttbr
);

	mmu_base ttbr;
	word domain, far;
	cp15_pkg::fault_status fsr;

	// ************************************************************
	// Translation base and domain access
	// ************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ttbr <= '0;
			domain <= '0;
		end else if (transfer) begin
			if (crn == `CP15_CRN_TTBR)
				ttbr <= write[31:14]; // Table is 16 KB aligned

			if (crn == `CP15_CRN_DOMAIN)
				domain <= write;
		end
	end

	// ************************************************************
	// Fault status and address
	// ************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fsr <= '0;
			far <= '0;
		end else if (fault) begin
			fsr <= fault_status; // Hardware capture beats a software write
			far <= fault_addr;
		end else if (transfer) begin
			if (crn == `CP15_CRN_FSR)
				fsr <= cp15_pkg::fault_status'(write[7:0]);

			if (crn == `CP15_CRN_FAR)
				far <= write;
		end
	end

	always_comb begin
		unique case (crn)
			`CP15_CRN_TTBR:   read = {ttbr, 14'b0};
			`CP15_CRN_DOMAIN: read = domain;
			`CP15_CRN_FSR:    read = {24'b0, fsr};
			`CP15_CRN_FAR:    read = far;
			default:          read = '0;
		endcase
	end

	assign mmu_ttbr = ttbr;

endmodule

//--- hdl/cp15_maint.sv
`include "cp15_settings.svh"

module cp15_maint
	import cp15_pkg::*;
(
	input  logic   clk,
	               rst_n,
	               transfer,
	input  reg_num crn,
	input  word    write,

	output word    read,
	output logic   cache_flush,
	               tlb_flush
);

	word cache_lck, tlb_lck;

	// ************************************************************
	// Maintenance strobes
	// ************************************************************

	// The write data selects a line or an MVA in a full core and is not used here
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cache_flush <= 1'b0;
			tlb_flush <= 1'b0;
		end else begin
			cache_flush <= transfer && crn == `CP15_CRN_CACHE; // One cycle wide
			tlb_flush <= transfer && crn == `CP15_CRN_TLB;
		end
	end

	// ************************************************************
	// Lockdown registers
	// ************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cache_lck <= '0;
			tlb_lck <= '0;
		end else if (transfer) begin
			if (crn == `CP15_CRN_CACHE_LCK)
				cache_lck <= write & `CP15_LCK_MASK;

			if (crn == `CP15_CRN_TLB_LCK)
				tlb_lck <= write & `CP15_LCK_MASK;
		end
	end

	always_comb begin
		unique case (crn)
			`CP15_CRN_CACHE_LCK: read = cache_lck;
			`CP15_CRN_TLB_LCK:   read = tlb_lck;
			default:             read = '0;
		endcase
	end

endmodule

//--- hdl/cp15_bank.sv
`include "cp15_settings.svh"

module cp15_bank
	import cp15_pkg::*;
(
	input  logic                  clk,
	                              rst_n,
	                              transfer,
	input  cp_dir                 dir,
	input  reg_num                crn,
	input  word                   write,
	input  logic                  fault,
	input  word                   fault_addr,
	input  cp15_pkg::fault_status fault_status,

	output word                   read,
	output logic                  mmu_enable,
	                              high_vectors,
	output mmu_base               mmu_ttbr,
	output logic                  cache_flush,
	                              tlb_flush
);

	logic wr_en, sys_sel, mmu_sel, maint_sel;
	word sys_read, mmu_read, maint_read;

	// ************************************************************
	// Write steering
	// ************************************************************

	assign wr_en = transfer && dir == CP_MCR; // Reads never touch state

	assign sys_sel = crn == `CP15_CRN_SYSCFG;
	assign mmu_sel = crn inside {`CP15_CRN_TTBR, `CP15_CRN_DOMAIN,
	                             `CP15_CRN_FSR, `CP15_CRN_FAR};
	assign maint_sel = crn inside {`CP15_CRN_CACHE, `CP15_CRN_TLB,
	                               `CP15_CRN_CACHE_LCK, `CP15_CRN_TLB_LCK};

	cp15_syscfg syscfg0 (
		.clk(clk),
		.rst_n(rst_n),
		.transfer(wr_en && sys_sel),
		.write(write),
		.read(sys_read),
		.mmu_enable(mmu_enable),
		.high_vectors(high_vectors)
	);

	cp15_mmu_regs mmu_regs0 (
		.clk(clk),
		.rst_n(rst_n),
		.transfer(wr_en && mmu_sel),
		.crn(crn),
		.write(write),
		.fault(fault),
		.fault_addr(fault_addr),
		.fault_status(fault_status),
		.read(mmu_read),
		.mmu_ttbr(mmu_ttbr)
	);

	cp15_maint maint0 (
		.clk(clk),
		.rst_n(rst_n),
		.transfer(wr_en && maint_sel),
		.crn(crn),
		.write(write),
		.read(maint_read),
		.cache_flush(cache_flush),
		.tlb_flush(tlb_flush)
	);

	// ************************************************************
	// Read mux
	// ************************************************************

	always_comb begin
		if (crn == `CP15_CRN_CPUID)
			read = `CP15_CPUID_VALUE;
		else if (sys_sel)
			read = sys_read;
		else if (mmu_sel)
			read = mmu_read;
		else if (maint_sel)
			read = maint_read; // Zero for the flush registers
		else
			read = '0;
	end

endmodule

//--- hdl/cp15_result.sv
module cp15_result
	import cp15_pkg::*;
(
	input  logic   clk,
	               rst_n,
	               transfer,
	input  cp_dir  dir,
	input  reg_num rt,
	input  word    read,
	input  logic   undef_in,

	output logic   rd_valid,
	output reg_num rd,
	output word    rd_data,
	output logic   undef
);

	logic wb_en;

	assign wb_en = transfer && dir == CP_MRC;

	// ************************************************************
	// Write-back stage
	// ************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			undef <= 1'b0;
		end else begin
			rd_valid <= wb_en;
			undef <= undef_in; // Core takes the undefined instruction trap
		end
	end

	always_ff @(posedge clk) begin
		if (wb_en) begin
			rd <= rt;
			rd_data <= read;
		end
	end

endmodule

//--- hdl/cp15_top.sv
module cp15_top
	import cp15_pkg::*;
(
	input  logic                  clk,
	                              rst_n,
	                              insn_valid,
	input  word                   insn,
	                              write_data,
	input  logic                  fault,
	input  word                   fault_addr,
	input  cp15_pkg::fault_status fault_status,

	output logic                  rd_valid,
	output reg_num                rd,
	output word                   rd_data,
	output logic                  undef,
	                              mmu_enable,
	                              high_vectors,
	output mmu_base               mmu_ttbr,
	output logic                  cache_flush,
	                              tlb_flush
);

	logic transfer, dec_undef;
	cp_dir dir;
	reg_num crn, rt;
	word read;

	cp15_decode decode0 (
		.insn_valid(insn_valid),
		.insn(insn),
		.transfer(transfer),
		.dir(dir),
		.crn(crn),
		.crm(), // No CRm sub-selection in this core
		.op1(),
		.op2(),
		.rt(rt),
		.undef(dec_undef)
	);

	cp15_bank bank0 (
		.clk(clk),
		.rst_n(rst_n),
		.transfer(transfer),
		.dir(dir),
		.crn(crn),
		.write(write_data),
		.fault(fault),
		.fault_addr(fault_addr),
		.fault_status(fault_status),
		.read(read),
		.mmu_enable(mmu_enable),
		.high_vectors(high_vectors),
		.mmu_ttbr(mmu_ttbr),
		.cache_flush(cache_flush),
		.tlb_flush(tlb_flush)
	);

	cp15_result result0 (
		.clk(clk),
		.rst_n(rst_n),
		.transfer(transfer),
		.dir(dir),
		.rt(rt),
		.read(read),
		.undef_in(dec_undef),
		.rd_valid(rd_valid),
		.rd(rd),
		.rd_data(rd_data),
		.undef(undef)
	);

endmodule

//--- sim/cp15_tb.sv
`include "cp15_settings.svh"

module cp15_tb
	import cp15_pkg::*;
();

	localparam int PERIOD = 40;
	localparam int N_OPS = 2000;
	localparam int RESET_CYCLES = 3;

	logic clk, rst_n, insn_valid, fault;
	word insn, write_data, fault_addr;
	cp15_pkg::fault_status fstat;
	logic rd_valid, undef, mmu_enable, high_vectors, cache_flush, tlb_flush;
	reg_num rd;
	word rd_data;
	mmu_base mmu_ttbr;

	word sh_ctrl, sh_domain, sh_far, sh_clck, sh_tlck;
	mmu_base sh_ttbr;
	logic [7:0] sh_fsr;
	logic exp_rd_valid, exp_undef, exp_cache_flush, exp_tlb_flush;
	reg_num exp_rd;
	word exp_rd_data;
	int value_errors, protocol_errors;
	logic [31:0] seed;

	reg_num impl_crn [10] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10};
	reg_num unimpl_crn [6] = '{4'd4, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15};

	cp15_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.insn_valid(insn_valid),
		.insn(insn),
		.write_data(write_data),
		.fault(fault),
		.fault_addr(fault_addr),
		.fault_status(fstat),
		.rd_valid(rd_valid),
		.rd(rd),
		.rd_data(rd_data),
		.undef(undef),
		.mmu_enable(mmu_enable),
		.high_vectors(high_vectors),
		.mmu_ttbr(mmu_ttbr),
		.cache_flush(cache_flush),
		.tlb_flush(tlb_flush)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// ************************************************************
	// Reference model
	// ************************************************************

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic ref_undef(input word i);
		logic legal, known;
		reg_num crn;
		crn = i[19:16];
		legal = i[27:24] == 4'b1110 && i[4] && i[11:8] == 4'd15;
		case (crn)
			4'd0, 4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10: known = 1'b1;
			default: known = 1'b0;
		endcase
		return !legal || !known || (i[20] && (crn == 4'd7 || crn == 4'd8))
			|| (!i[20] && crn == 4'd0);
	endfunction

	function automatic word ref_read(input reg_num crn);
		case (crn)
			`CP15_CRN_CPUID:     return `CP15_CPUID_VALUE;
			`CP15_CRN_SYSCFG:    return sh_ctrl;
			`CP15_CRN_TTBR:      return {sh_ttbr, 14'b0};
			`CP15_CRN_DOMAIN:    return sh_domain;
			`CP15_CRN_FSR:       return {24'b0, sh_fsr};
			`CP15_CRN_FAR:       return sh_far;
			`CP15_CRN_CACHE_LCK: return sh_clck;
			`CP15_CRN_TLB_LCK:   return sh_tlck;
			default:             return '0;
		endcase
	endfunction

	task automatic reset_model();
		sh_ctrl = '0;
		sh_domain = '0;
		sh_far = '0;
		sh_clck = '0;
		sh_tlck = '0;
		sh_ttbr = '0;
		sh_fsr = '0;
		exp_rd_valid = 1'b0;
		exp_undef = 1'b0;
		exp_cache_flush = 1'b0;
		exp_tlb_flush = 1'b0;
	endtask

	task automatic predict();
		logic is_undef, is_mcr;
		reg_num crn;
		crn = insn[19:16];
		is_undef = insn_valid && ref_undef(insn);
		is_mcr = insn_valid && !is_undef && !insn[20];
		exp_undef = is_undef;
		exp_rd_valid = insn_valid && !is_undef && insn[20];
		exp_rd = insn[15:12];
		exp_rd_data = ref_read(crn); // Read sees the value before this edge
		exp_cache_flush = is_mcr && crn == `CP15_CRN_CACHE;
		exp_tlb_flush = is_mcr && crn == `CP15_CRN_TLB;
		if (is_mcr) begin
			case (crn)
				`CP15_CRN_SYSCFG:    sh_ctrl = write_data & `CP15_SYSCFG_MASK;
				`CP15_CRN_TTBR:      sh_ttbr = write_data[31:14];
				`CP15_CRN_DOMAIN:    sh_domain = write_data;
				`CP15_CRN_FSR:       sh_fsr = write_data[7:0];
				`CP15_CRN_FAR:       sh_far = write_data;
				`CP15_CRN_CACHE_LCK: sh_clck = write_data & `CP15_LCK_MASK;
				`CP15_CRN_TLB_LCK:   sh_tlck = write_data & `CP15_LCK_MASK;
				default: ;
			endcase
		end
		if (fault) begin
			sh_far = fault_addr; // Applied last so the fault overrides the write
			sh_fsr = fstat;
		end
	endtask

	// ************************************************************
	// Compare tasks
	// ************************************************************

	task automatic check_word(input string name, input word got, input word exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_reg(input string name, input reg_num got, input reg_num exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_base(input string name, input mmu_base got, input mmu_base exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Outputs seen here were registered at the previous edge
	always @(posedge clk) begin
		if (!rst_n) begin
			reset_model();
		end else begin
			check_bit("undef", undef, exp_undef);
			check_bit("cache_flush", cache_flush, exp_cache_flush);
			check_bit("tlb_flush", tlb_flush, exp_tlb_flush);
			check_bit("mmu_enable", mmu_enable, sh_ctrl[`CP15_SYSCFG_M_BIT]);
			check_bit("high_vectors", high_vectors, sh_ctrl[`CP15_SYSCFG_V_BIT]);
			check_base("mmu_ttbr", mmu_ttbr, sh_ttbr);
			if (rd_valid !== exp_rd_valid) begin
				protocol_errors++;
				if (exp_rd_valid)
					$display("Missing write-back: no rd_valid after an MRC at %0t", $time);
				else
					$display("Unexpected rd_valid with no MRC before it at %0t", $time);
			end else if (exp_rd_valid) begin
				check_reg("rd", rd, exp_rd);
				check_word("rd_data", rd_data, exp_rd_data);
			end
			predict();
		end
	end

	// ************************************************************
	// Stimulus
	// ************************************************************

	function automatic word make_insn(input cp_dir d, input reg_num crn, input reg_num rt,
		input logic [31:0] fill);
		word i;
		i = fill; // Condition, op1, op2 and CRm stay random
		i[27:24] = 4'b1110;
		i[20] = d == CP_MRC;
		i[19:16] = crn;
		i[15:12] = rt;
		i[11:8] = 4'd15;
		i[4] = 1'b1;
		return i;
	endfunction

	task automatic issue(input logic v, input word i, input word d, input logic f,
		input word fa, input logic [7:0] fs);
		@(negedge clk);
		insn_valid = v;
		insn = i;
		write_data = d;
		fault = f;
		fault_addr = fa;
		fstat = fs;
	endtask

	initial begin
		logic [31:0] r, data, fa, status;
		word i;
		cp_dir d;
		reg_num crn, last_crn;
		logic f;
		insn_valid = 1'b0;
		insn = '0;
		write_data = '0;
		fault = 1'b0;
		fault_addr = '0;
		fstat = '0;
		rst_n = 1'b0;
		seed = 32'h207f;
		value_errors = 0;
		protocol_errors = 0;
		last_crn = `CP15_CRN_SYSCFG;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		issue(1'b1, make_insn(CP_MRC, `CP15_CRN_CPUID, 4'd3, 32'h0), '0, 1'b0, '0, '0);
		for (int n = 0; n < N_OPS; n++) begin
			seed = xorshift(seed);
			r = seed;
			d = cp_dir'(r[0]);
			case (r[7:4])
				4'd0: crn = unimpl_crn[r[10:8] % 6];
				4'd1, 4'd2: begin
					crn = last_crn; // Read back the last register written
					d = CP_MRC;
				end
				default: crn = impl_crn[r[11:8] % 10];
			endcase
			f = r[24:22] == 3'd0;
			if (f && r[25]) begin
				crn = r[26] ? `CP15_CRN_FSR : `CP15_CRN_FAR; // Collide with the fault
				d = CP_MCR;
			end
			seed = xorshift(seed);
			data = seed;
			seed = xorshift(seed);
			fa = seed;
			seed = xorshift(seed);
			status = seed;
			seed = xorshift(seed);
			i = make_insn(d, crn, r[15:12], seed);
			if (r[19:17] == 3'd0) begin
				case (r[21:20])
					2'd0: i[24] = 1'b1;
					2'd1: i[4] = 1'b0;
					2'd2: i[11:8] = 4'd14;
					default: i[26] = 1'b0;
				endcase
			end
			if (d == CP_MCR)
				last_crn = crn;
			issue(1'b1, i, data, f, fa, status[7:0]);
			if (r[28:27] == 2'd0)
				issue(1'b0, '0, '0, 1'b0, '0, '0);
		end
		repeat (3) issue(1'b0, '0, '0, 1'b0, '0, '0);
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(N_OPS * 4 * PERIOD + (RESET_CYCLES + 4) * PERIOD);
		$display("Timeout: the stimulus did not finish in the allowed time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/cp15_pkg.sv
hdl/cp15_decode.sv
hdl/cp15_syscfg.sv
hdl/cp15_mmu_regs.sv
hdl/cp15_maint.sv
hdl/cp15_bank.sv
hdl/cp15_result.sv
hdl/cp15_top.sv
sim/cp15_tb.sv
